//--- Makefile
VERILATOR ?= verilator
SIMFLAGS  = --binary --timing --assert
LINTFLAGS = --lint-only --timing
TOP       = decodeStageTb
FILELIST  = mipsDecode.f
OBJDIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench makes the binary, and so make, fail
sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- hw/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	//////////////////////////////
	// pipeline timing
	//////////////////////////////

	// cycles until a value is needed (Tuse) or ready (Tnew)
	typedef logic [1:0] tTime;

	// tuse for an operand the instruction never reads
	localparam tTime TUSE_NEVER = 2'd3;

	//////////////////////////////
	// datapath select codes
	//////////////////////////////

	// next pc source
	typedef logic [1:0] jumpSel;
	localparam jumpSel JUMP_ADDER  = 2'b00;
	localparam jumpSel JUMP_IMM16  = 2'b01;
	localparam jumpSel JUMP_IMM26  = 2'b10;
	localparam jumpSel JUMP_RDATA1 = 2'b11;

	// alu operation
	typedef logic [2:0] aluOp;
	localparam aluOp ALU_ADD = 3'b000;
	localparam aluOp ALU_SUB = 3'b001;
	localparam aluOp ALU_OR  = 3'b010;
	localparam aluOp ALU_LUI = 3'b011;
	// swc kept in the code space of the full ALU
	localparam aluOp ALU_SWC = 3'b100;

	// alu second operand
	typedef logic [1:0] data2Sel;
	localparam data2Sel DATA2_RDATA2   = 2'b00;
	localparam data2Sel DATA2_EXT      = 2'b01;
	localparam data2Sel DATA2_ZERO_EXT = 2'b10;

	// register write data
	typedef logic [1:0] wdataSel;
	localparam wdataSel WDATA_ANS   = 2'b00;
	localparam wdataSel WDATA_RDATA = 2'b01;
	localparam wdataSel WDATA_ADDER = 2'b10;

	// operand source for rs and rt
	typedef logic [2:0] fwdSel;
	localparam fwdSel FWD_GRF    = 3'd0;
	localparam fwdSel FWD_FROM_E = 3'd1;
	localparam fwdSel FWD_FROM_M = 3'd2;
	localparam fwdSel FWD_FROM_W = 3'd3;
	// writer in flight but not done, resolved further down
	localparam fwdSel FWD_LATE   = 3'd4;

	// controls carried into E
	typedef struct packed {
		aluOp          aluOp;
		data2Sel       data2Sel;
		wdataSel       wdataSel;
		isaPkg::regIdx wreg;
		logic          grfWe;
		logic          dmWe;
		logic          isLoad;
		logic          isStore;
		logic [15:0]   imm16;
	} execCtrl;

endpackage

`default_nettype wire

//--- hw/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage
	import isaPkg::*, ctrlPkg::*;
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic [31:0] instr,
	input  wire logic        instrValid,
	// D stage, same cycle as instr
	output logic             stall,
	output fwdSel            rsFwd,
	output fwdSel            rtFwd,
	output ctrlPkg::jumpSel  jumpSelD,
	// E stage, one clock later
	output logic             eValid,
	output aluOp             eAluOp,
	output data2Sel          eData2Sel,
	output wdataSel          eWdataSel,
	output regIdx            eWreg,
	output logic             eGrfWe,
	output logic             eDmWe,
	output logic [15:0]      eImm16
);

	execCtrl ctrlD;
	execCtrl eCtrl;
	regIdx   destReg;
	tTime    eTnewD;
	tTime    mTnewD;

	regUseIf useBus();
	stageIf  stageBus();

	//////////////////////////////
	// D stage blocks
	//////////////////////////////

	instrDecoder uDecoder (
		.instr   (instr),
		.uses    (useBus.src),
		.ctrl    (ctrlD),
		.jumpSel (jumpSelD),
		.destReg (destReg),
		.eTnew   (eTnewD),
		.mTnew   (mTnewD)
	);

	stageTracker uTracker (
		.clk        (clk),
		.reset      (reset),
		.instrValid (instrValid),
		.stall      (stall),
		.destReg    (destReg),
		.eTnewIn    (eTnewD),
		.mTnewIn    (mTnewD),
		.stages     (stageBus.src)
	);

	hazardResolver uResolver (
		.uses   (useBus.dst),
		.stages (stageBus.dst),
		.stall  (stall),
		.rsFwd  (rsFwd),
		.rtFwd  (rtFwd)
	);

	//////////////////////////////
	// E stage register
	//////////////////////////////

	// same issue rule as the tracker, bubble otherwise
	always_ff @(posedge clk) begin
		if (reset || !instrValid || stall) begin
			eCtrl  <= '0;
			eValid <= 1'b0;
		end else begin
			eCtrl  <= ctrlD;
			eValid <= 1'b1;
		end
	end

	assign eAluOp    = eCtrl.aluOp;
	assign eData2Sel = eCtrl.data2Sel;
	assign eWdataSel = eCtrl.wdataSel;
	assign eWreg     = eCtrl.wreg;
	assign eGrfWe    = eCtrl.grfWe;
	assign eDmWe     = eCtrl.dmWe;
	assign eImm16    = eCtrl.imm16;

endmodule

`default_nettype wire

//--- hw/hazardIf.sv
`timescale 1ns/1ns
`default_nettype none

//////////////////////////////
// operand use of the D instruction
//////////////////////////////

interface regUseIf
	import isaPkg::*, ctrlPkg::*;
();
	// source register numbers, raw fields
	regIdx rs;
	regIdx rt;
	// cycles until each is read
	tTime  tUseRs;
	tTime  tUseRt;

	modport src (output rs, rt, tUseRs, tUseRt);
	modport dst (input rs, rt, tUseRs, tUseRt);
endinterface

//////////////////////////////
// writers in flight
//////////////////////////////

interface stageIf
	import isaPkg::*, ctrlPkg::*;
();
	// destination per stage, 0 for no write
	regIdx eReg;
	tTime  eTnew;
	regIdx mReg;
	tTime  mTnew;
	// W result always ready
	regIdx wReg;

	modport src (output eReg, eTnew, mReg, mTnew, wReg);
	modport dst (input eReg, eTnew, mReg, mTnew, wReg);
endinterface

`default_nettype wire

//--- hw/hazardResolver.sv
`timescale 1ns/1ns
`default_nettype none

module hazardResolver
	import isaPkg::*, ctrlPkg::*;
(
	regUseIf.dst  uses,
	stageIf.dst   stages,
	output logic  stall,
	output fwdSel rsFwd,
	output fwdSel rtFwd
);

	// local copies of the in-flight writers
	regIdx eReg;
	tTime  eTnew;
	regIdx mReg;
	tTime  mTnew;
	regIdx wReg;

	assign eReg  = stages.eReg;
	assign eTnew = stages.eTnew;
	assign mReg  = stages.mReg;
	assign mTnew = stages.mTnew;
	assign wReg  = stages.wReg;

	//////////////////////////////
	// stall
	//////////////////////////////

	// needed sooner than any forward can supply it
	function automatic logic needsStall(input regIdx r, input tTime tUse,
		input regIdx er, input tTime et, input regIdx mr, input tTime mt);
		logic hitE;
		logic hitM;
		hitE = (r == er) && (tUse < et);
		hitM = (r == mr) && (tUse < mt);
		return (r != REG_ZERO) && (hitE || hitM);
	endfunction

	assign stall = needsStall(uses.rs, uses.tUseRs, eReg, eTnew, mReg, mTnew) ||
		needsStall(uses.rt, uses.tUseRt, eReg, eTnew, mReg, mTnew);

	//////////////////////////////
	// operand source
	//////////////////////////////

	// youngest writer wins, E before M before W
	function automatic fwdSel pickSource(input regIdx r, input regIdx er, input tTime et,
		input regIdx mr, input tTime mt, input regIdx wr);
		fwdSel sel;
		if (r == REG_ZERO)
			sel = FWD_GRF;
		else if (r == er)
			sel = (et == 2'd0) ? FWD_FROM_E : FWD_LATE;
		else if (r == mr)
			sel = (mt == 2'd0) ? FWD_FROM_M : FWD_LATE;
		else if (r == wr)
			sel = FWD_FROM_W;
		else
			sel = FWD_GRF;
		return sel;
	endfunction

	assign rsFwd = pickSource(uses.rs, eReg, eTnew, mReg, mTnew, wReg);
	assign rtFwd = pickSource(uses.rt, eReg, eTnew, mReg, mTnew, wReg);

endmodule

`default_nettype wire

//--- hw/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
	import isaPkg::*, ctrlPkg::*;
(
	input  wire logic [31:0]    instr,
	regUseIf.src                uses,
	output execCtrl             ctrl,
	output ctrlPkg::jumpSel     jumpSel,
	output regIdx               destReg,
	output tTime                eTnew,
	output tTime                mTnew
);

	//////////////////////////////
	// fields
	//////////////////////////////

	logic [5:0]  opcode;
	logic [5:0]  funct;
	regIdx       rs;
	regIdx       rt;
	regIdx       rd;

	assign opcode = instr[OP_LSB +: 6];
	assign funct  = instr[FUNCT_LSB +: 6];
	assign rs     = instr[RS_LSB +: 5];
	assign rt     = instr[RT_LSB +: 5];
	assign rd     = instr[RD_LSB +: 5];

	// one flag per instruction
	logic isAdd, isSub, isOri, isLui, isLw, isSw, isBeq, isJal, isJr;

	assign isAdd = (opcode == OP_R) && (funct == FUNCT_ADD);
	assign isSub = (opcode == OP_R) && (funct == FUNCT_SUB);
	assign isJr  = (opcode == OP_R) && (funct == FUNCT_JR);
	assign isOri = (opcode == OP_ORI);
	assign isLui = (opcode == OP_LUI);
	assign isLw  = (opcode == OP_LW);
	assign isSw  = (opcode == OP_SW);
	assign isBeq = (opcode == OP_BEQ);
	assign isJal = (opcode == OP_JAL);

	//////////////////////////////
	// next pc source
	//////////////////////////////

	always_comb begin
		if (isBeq)
			jumpSel = JUMP_IMM16;
		else if (isJal)
			jumpSel = JUMP_IMM26;
		else if (isJr)
			jumpSel = JUMP_RDATA1;
		else
			jumpSel = JUMP_ADDER;
	end

	//////////////////////////////
	// execute controls
	//////////////////////////////

	always_comb begin
		ctrl = '0;
		// alu op, loads and stores compute address by add
		if (isSub)
			ctrl.aluOp = ALU_SUB;
		else if (isOri)
			ctrl.aluOp = ALU_OR;
		else if (isLui)
			ctrl.aluOp = ALU_LUI;
		else
			ctrl.aluOp = ALU_ADD;
		// second operand
		if (isLui || isLw || isSw)
			ctrl.data2Sel = DATA2_EXT;
		else if (isOri)
			ctrl.data2Sel = DATA2_ZERO_EXT;
		else
			ctrl.data2Sel = DATA2_RDATA2;
		// write data, jal links pc+8 from the adder
		if (isLw)
			ctrl.wdataSel = WDATA_RDATA;
		else if (isJal)
			ctrl.wdataSel = WDATA_ADDER;
		else
			ctrl.wdataSel = WDATA_ANS;
		// destination, zero when nothing is written
		if (isAdd || isSub)
			ctrl.wreg = rd;
		else if (isOri || isLui || isLw)
			ctrl.wreg = rt;
		else if (isJal)
			ctrl.wreg = REG_RA;
		else
			ctrl.wreg = REG_ZERO;
		ctrl.grfWe   = isAdd || isSub || isOri || isLui || isLw || isJal;
		ctrl.dmWe    = isSw;
		ctrl.isLoad  = isLw;
		ctrl.isStore = isSw;
		ctrl.imm16   = instr[IMM16_LSB +: 16];
	end

	assign destReg = ctrl.wreg;

	//////////////////////////////
	// tuse and tnew
	//////////////////////////////

	assign uses.rs = rs;
	assign uses.rt = rt;

	// rs read in E by alu users, in D by branch and jr
	assign uses.tUseRs = (isAdd || isSub || isOri || isLw || isSw) ? 2'd1 :
		(isBeq || isJr) ? 2'd0 : TUSE_NEVER;
	// store data is needed only in M
	assign uses.tUseRt = (isAdd || isSub) ? 2'd1 :
		isSw ? 2'd2 :
		isBeq ? 2'd0 : TUSE_NEVER;

	// alu results ready after E, load data after M
	assign eTnew = (isAdd || isSub || isOri || isLui) ? 2'd1 :
		isLw ? 2'd2 : 2'd0;
	assign mTnew = isLw ? 2'd1 : 2'd0;

endmodule

`default_nettype wire

//--- hw/isaPkg.sv
`default_nettype none

package isaPkg;

	//////////////////////////////
	// primary opcodes, bits 31:26
	//////////////////////////////

	// special, decoded further by funct
	localparam logic [5:0] OP_R   = 6'b000000;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_LUI = 6'b001111;
	localparam logic [5:0] OP_LW  = 6'b100011;
	localparam logic [5:0] OP_SW  = 6'b101011;
	localparam logic [5:0] OP_BEQ = 6'b000100;
	localparam logic [5:0] OP_JAL = 6'b000011;

	// funct codes under OP_R
	localparam logic [5:0] FUNCT_ADD = 6'b100000;
	localparam logic [5:0] FUNCT_SUB = 6'b100010;
	localparam logic [5:0] FUNCT_JR  = 6'b001000;

	//////////////////////////////
	// instruction fields
	//////////////////////////////

	// low bit of each field
	localparam int OP_LSB    = 26;
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int FUNCT_LSB = 0;
	localparam int IMM16_LSB = 0;

	// register number
	typedef logic [4:0] regIdx;

	// $0 doubles as "no write" in the hazard logic
	localparam regIdx REG_ZERO = 5'd0;
	// link register for jal
	localparam regIdx REG_RA   = 5'd31;

endpackage

`default_nettype wire

//--- hw/stageTracker.sv
`timescale 1ns/1ns
`default_nettype none

module stageTracker
	import isaPkg::*, ctrlPkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic instrValid,
	input  wire logic stall,
	input  wire regIdx destReg,
	input  wire tTime eTnewIn,
	input  wire tTime mTnewIn,
	stageIf.src       stages
);

	// D instruction moves into E this edge
	logic  issue;

	// E slot, with the tnew it will carry into M
	regIdx eReg;
	tTime  eTnew;
	tTime  eMTnew;
	// M and W slots
	regIdx mReg;
	tTime  mTnew;
	regIdx wReg;

	assign issue = instrValid && !stall;

	//////////////////////////////
	// stage advance
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			eReg   <= REG_ZERO;
			eTnew  <= 2'd0;
			eMTnew <= 2'd0;
			mReg   <= REG_ZERO;
			mTnew  <= 2'd0;
			wReg   <= REG_ZERO;
		end else begin
			if (issue) begin
				eReg   <= destReg;
				eTnew  <= eTnewIn;
				eMTnew <= mTnewIn;
			end else begin
				// bubble, never matches an operand
				eReg   <= REG_ZERO;
				eTnew  <= 2'd0;
				eMTnew <= 2'd0;
			end
			// M tnew comes from decode, not a decrement
			mReg  <= eReg;
			mTnew <= eMTnew;
			wReg  <= mReg;
		end
	end

	assign stages.eReg  = eReg;
	assign stages.eTnew = eTnew;
	assign stages.mReg  = mReg;
	assign stages.mTnew = mTnew;
	assign stages.wReg  = wReg;

endmodule

`default_nettype wire

//--- mipsDecode.f
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/hazardIf.sv
hw/instrDecoder.sv
hw/stageTracker.sv
hw/hazardResolver.sv
hw/decodeStage.sv
test/decodeStageTb.sv

//--- test/decodeGolden.txt
# instr valid stall rsFwd rtFwd jumpSelD, then E outputs of the previous line:
# eValid eAluOp eData2Sel eWdataSel eWreg eGrfWe eDmWe eImm16 (all hex)
00000000 0 0 0 0 0 0 0 0 0 00 0 0 0000
# every instruction once, independent registers
00221820 1 0 0 0 0 0 0 0 0 00 0 0 0000
00853022 1 0 0 0 0 1 0 0 0 03 1 0 1820
34e800ff 1 0 0 0 0 1 1 0 0 06 1 0 3022
3c091234 1 0 0 0 0 1 2 2 0 08 1 0 00ff
8d4b0004 1 0 0 0 0 1 3 1 0 09 1 0 1234
ad8d0008 1 0 0 0 0 1 0 1 1 0b 1 0 0004
11cf0010 1 0 0 0 1 1 0 1 0 00 0 1 0008
0c000040 1 0 0 0 2 1 0 0 0 00 0 0 0010
03e00008 1 0 1 0 3 1 0 0 2 1f 1 0 0040
# load-use stall, then beq behind an add
8c220000 1 0 0 0 0 1 0 0 0 00 0 0 0008
00432020 1 1 4 0 0 1 0 1 1 02 1 0 0000
00432020 1 0 4 0 0 0 0 0 0 00 0 0 0000
10800008 1 1 4 0 1 1 0 0 0 04 1 0 2020
10800008 1 0 2 0 1 0 0 0 0 00 0 0 0000
# forwarding at distance one, two and three
00222820 1 0 0 0 0 1 0 0 0 00 0 0 0008
00a13020 1 0 4 0 0 1 0 0 0 05 1 0 2820
00253822 1 0 0 2 0 1 0 0 0 06 1 0 3020
34a90001 1 0 3 0 0 1 1 0 0 07 1 0 3822
# register zero and invalid slots
00220020 1 0 0 0 0 1 2 2 0 09 1 0 0001
00001820 1 0 0 0 0 1 0 0 0 00 1 0 0020
00000000 0 0 0 0 0 1 0 0 0 03 1 0 1820
00034020 1 0 0 2 0 0 0 0 0 00 0 0 0000
8d0c0000 1 0 4 0 0 1 0 0 0 08 1 0 4020
00000000 0 0 0 0 0 1 0 1 1 0c 1 0 0000
01886820 1 0 4 3 0 0 0 0 0 00 0 0 0000
ad8d0004 1 0 3 4 0 1 0 0 0 0d 1 0 6820
00000000 0 0 0 0 0 1 0 1 0 00 0 1 0004
00000000 0 0 0 0 0 0 0 0 0 00 0 0 0000
end

//--- test/decodeStageTb.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb
	import isaPkg::*, ctrlPkg::*;
();

	localparam string GOLDEN_PATH  = "test/decodeGolden.txt";
	localparam int    RESET_CYCLES = 16;
	localparam int    MAX_LINES    = 200;
	localparam int    FIELD_COUNT  = 14;
	// comb outputs sampled 1 ns before the rising edge
	localparam int    SAMPLE_DELAY = 3;
	// lw $3 from $3, valid through reset so only reset keeps E and the tracker empty
	localparam logic [31:0] RESET_INSTR = 32'h8c630000;

	logic        clk;
	logic        reset;
	logic [31:0] instr;
	logic        instrValid;
	logic        stall;
	fwdSel       rsFwd;
	fwdSel       rtFwd;
	jumpSel      jumpSelD;
	logic        eValid;
	aluOp        eAluOp;
	data2Sel     eData2Sel;
	wdataSel     eWdataSel;
	regIdx       eWreg;
	logic        eGrfWe;
	logic        eDmWe;
	logic [15:0] eImm16;

	// golden line currently applied
	int lineNo;
	int vectors;

	decodeStage dut (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.instrValid (instrValid),
		.stall      (stall),
		.rsFwd      (rsFwd),
		.rtFwd      (rtFwd),
		.jumpSelD   (jumpSelD),
		.eValid     (eValid),
		.eAluOp     (eAluOp),
		.eData2Sel  (eData2Sel),
		.eWdataSel  (eWdataSel),
		.eWreg      (eWreg),
		.eGrfWe     (eGrfWe),
		.eDmWe      (eDmWe),
		.eImm16     (eImm16)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic checkField(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h (golden line %0d)",
				$time, name, got, expected, lineNo);
			$display("TESTS FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	// comment lines start with #
	function automatic bit isCommentOrBlank(input string text);
		if (text.len() == 0)
			return 1'b1;
		return (text[0] == "#") || (text[0] == "\n") || (text[0] == "\r");
	endfunction

	//////////////////////////////
	// stimulus and checks
	//////////////////////////////

	initial begin
		int          fd;
		int          count;
		int          cycle;
		bit          sawEnd;
		string       line;
		string       word;
		logic [31:0] expInstr, expValid, expStall, expRsFwd, expRtFwd, expJump;
		logic [31:0] expEValid, expEAluOp, expEData2, expEWdata;
		logic [31:0] expEWreg, expEGrfWe, expEDmWe, expEImm16;

		reset      = 1'b1;
		instr      = RESET_INSTR;
		instrValid = 1'b1;
		lineNo     = 0;
		vectors    = 0;
		sawEnd     = 1'b0;

		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0)
			abortRun("cannot open the golden file test/decodeGolden.txt");

		// hold reset
		for (cycle = 0; cycle < RESET_CYCLES; cycle++) begin
			@(posedge clk);
		end
		@(negedge clk);

		// still in reset so nothing issued and no hazards
		checkField("eValid", 32'(eValid), 32'd0);
		checkField("eGrfWe", 32'(eGrfWe), 32'd0);
		checkField("eDmWe", 32'(eDmWe), 32'd0);
		checkField("stall", 32'(stall), 32'd0);
		checkField("rsFwd", 32'(rsFwd), 32'(FWD_GRF));
		checkField("rtFwd", 32'(rtFwd), 32'(FWD_GRF));
		reset = 1'b0;

		// one vector per falling edge up to the line limit
		while (!sawEnd) begin
			if (lineNo >= MAX_LINES)
				abortRun("golden file has too many lines, read loop stopped");
			if ($fgets(line, fd) == 0)
				abortRun("golden file ended before its end marker");
			lineNo++;
			if (isCommentOrBlank(line))
				continue;
			count = $sscanf(line, "%s", word);
			if (word == "end") begin
				sawEnd = 1'b1;
			end else begin
				count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					expInstr, expValid, expStall, expRsFwd, expRtFwd, expJump,
					expEValid, expEAluOp, expEData2, expEWdata,
					expEWreg, expEGrfWe, expEDmWe, expEImm16);
				if (count != FIELD_COUNT)
					abortRun($sformatf("golden line %0d cannot be parsed", lineNo));

				// E outputs belong to the previous vector
				checkField("eValid", 32'(eValid), expEValid);
				checkField("eAluOp", 32'(eAluOp), expEAluOp);
				checkField("eData2Sel", 32'(eData2Sel), expEData2);
				checkField("eWdataSel", 32'(eWdataSel), expEWdata);
				checkField("eWreg", 32'(eWreg), expEWreg);
				checkField("eGrfWe", 32'(eGrfWe), expEGrfWe);
				checkField("eDmWe", 32'(eDmWe), expEDmWe);
				checkField("eImm16", 32'(eImm16), expEImm16);

				// drive D inputs
				instr      = expInstr;
				instrValid = expValid[0];
				vectors++;

				#SAMPLE_DELAY;
				checkField("stall", 32'(stall), expStall);
				checkField("rsFwd", 32'(rsFwd), expRsFwd);
				checkField("rtFwd", 32'(rtFwd), expRtFwd);
				checkField("jumpSelD", 32'(jumpSelD), expJump);
				@(negedge clk);
			end
		end
		$fclose(fd);

		if (vectors == 0) begin
			abortRun("golden file holds no vectors");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
